// File: hw/mem_pkg.sv
package mem_pkg;

	// word address into the shared memory
	localparam int ADDR_W = 10;

	// one bus word
	localparam int DATA_W = 32;

	// one enable per byte lane
	localparam int SEL_W = DATA_W / 8;

	// first word written by a ROM download
	localparam logic [ADDR_W-1:0] LOAD_BASE = '0;

endpackage

// File: hw/vid_pkg.sv
package vid_pkg;

	// video base clock select, as driven by the core
	typedef enum logic [1:0] {
		SEL_24A = 2'b00,
		SEL_25  = 2'b01,
		SEL_36  = 2'b10,
		SEL_24B = 2'b11
	} pixclk_sel_t;

	// per-channel colour depth at the connector
	localparam int COLOR_W = 6;

	// length of one PLL scan profile
	localparam int PROFILE_BITS = 16;

	// entries for 24, 25 and 36 MHz
	localparam logic [PROFILE_BITS-1:0] PROFILE_ROM [0:2] = '{
		16'h4a1c,
		16'h51e3,
		16'h6b07
	};

	// both 24 MHz codes share one profile
	function automatic logic [PROFILE_BITS-1:0] profile_of(input pixclk_sel_t sel);
		case (sel)
			SEL_25:  return PROFILE_ROM[1];
			SEL_36:  return PROFILE_ROM[2];
			default: return PROFILE_ROM[0];
		endcase
	endfunction

endpackage

// File: hw/boot_loader_mux.sv
`timescale 1ns/1ns

module boot_loader_mux (
	input  logic                       CLOCK_27,
	input  logic                       rst_n_i,
	// loader link
	input  logic                       loader_active_i,
	input  logic                       loader_req_i,
	input  logic [mem_pkg::ADDR_W-1:0] loader_addr_i,
	input  logic [mem_pkg::DATA_W-1:0] loader_data_i,
	input  logic [mem_pkg::SEL_W-1:0]  loader_sel_i,
	output logic                       loader_ack_o,
	// core bus
	input  logic                       core_stb_i,
	input  logic                       core_we_i,
	input  logic [mem_pkg::SEL_W-1:0]  core_sel_i,
	input  logic [mem_pkg::ADDR_W-1:0] core_adr_i,
	input  logic [mem_pkg::DATA_W-1:0] core_dat_i,
	output logic [mem_pkg::DATA_W-1:0] core_dat_o,
	output logic                       core_ack_o,
	output logic                       core_reset_o,
	// memory bus
	output logic                       ram_stb_o,
	output logic                       ram_we_o,
	output logic [mem_pkg::SEL_W-1:0]  ram_sel_o,
	output logic [mem_pkg::ADDR_W-1:0] ram_adr_o,
	output logic [mem_pkg::DATA_W-1:0] ram_wdat_o,
	input  logic [mem_pkg::DATA_W-1:0] ram_rdat_i,
	input  logic                       ram_ack_i
);

	logic req_q;
	logic ld_stb;
	logic active_q;
	logic rom_ready;
	logic core_done;

	// loader side of the handshake
	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			req_q        <= 1'b0;
			ld_stb       <= 1'b0;
			loader_ack_o <= 1'b0;
			active_q     <= 1'b0;
			rom_ready    <= 1'b0;
		end else begin
			req_q    <= loader_req_i;
			active_q <= loader_active_i;
			// rising req opens exactly one write
			if (loader_active_i && loader_req_i && !req_q)
				ld_stb <= 1'b1;
			else if (ram_ack_i || !loader_active_i)
				ld_stb <= 1'b0;
			// ack is held until the loader lets go of req
			if (ld_stb && ram_ack_i)
				loader_ack_o <= 1'b1;
			else if (!loader_req_i)
				loader_ack_o <= 1'b0;
			// end of the first download releases the core
			if (active_q && !loader_active_i)
				rom_ready <= 1'b1;
		end
	end

	// core side; one ack per strobe, none while loading
	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			core_ack_o <= 1'b0;
			core_done  <= 1'b0;
		end else begin
			core_ack_o <= ram_ack_i && !loader_active_i && core_stb_i && !core_done;
			if (!core_stb_i)
				core_done <= 1'b0;
			else if (ram_ack_i && !loader_active_i)
				core_done <= 1'b1;
		end
	end

	always_ff @(posedge CLOCK_27) begin
		if (ram_ack_i && !loader_active_i)
			core_dat_o <= ram_rdat_i;
	end

	assign core_reset_o = !rom_ready;

	// loader owns the memory for the whole download
	assign ram_stb_o  = loader_active_i ? ld_stb : (core_stb_i && !core_done);
	assign ram_we_o   = loader_active_i ? 1'b1 : core_we_i;
	assign ram_sel_o  = loader_active_i ? loader_sel_i : core_sel_i;
	assign ram_adr_o  = loader_active_i ? mem_pkg::LOAD_BASE + loader_addr_i : core_adr_i;
	assign ram_wdat_o = loader_active_i ? loader_data_i : core_dat_i;

endmodule

// File: hw/word_ram.sv
`timescale 1ns/1ns

module word_ram #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                       CLOCK_27,
	input  logic                       rst_n_i,
	input  logic                       ram_stb_i,
	input  logic                       ram_we_i,
	input  logic [mem_pkg::SEL_W-1:0]  ram_sel_i,
	input  logic [mem_pkg::ADDR_W-1:0] ram_adr_i,
	input  logic [mem_pkg::DATA_W-1:0] ram_wdat_i,
	output logic [mem_pkg::DATA_W-1:0] ram_rdat_o,
	output logic                       ram_ack_o
);

	logic [mem_pkg::DATA_W-1:0] mem [0:MEM_WORDS-1];

	// single ack per strobe, strobe still high during ack is ignored
	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i)
			ram_ack_o <= 1'b0;
		else
			ram_ack_o <= ram_stb_i && !ram_ack_o;
	end

	always_ff @(posedge CLOCK_27) begin
		if (ram_stb_i && !ram_ack_o) begin
			ram_rdat_o <= mem[ram_adr_i];
			if (ram_we_i) begin
				// byte lanes
				for (int i = 0; i < mem_pkg::SEL_W; i++) begin
					if (ram_sel_i[i])
						mem[ram_adr_i][8*i +: 8] <= ram_wdat_i[8*i +: 8];
				end
			end
		end
	end

endmodule

// File: hw/pixclk_reconfig.sv
`timescale 1ns/1ns

module pixclk_reconfig #(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic                 CLOCK_27,
	input  logic                 rst_n_i,
	input  vid_pkg::pixclk_sel_t pixclk_sel_i,
	input  logic                 engine_busy_i,
	output logic                 write_rom_req_o,
	output logic                 reconfig_req_o,
	output logic                 engine_reset_o,
	output vid_pkg::pixclk_sel_t profile_sel_o
);

	localparam int TMO_W = $clog2(RECONFIG_TIMEOUT + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SETTLE,
		S_WAIT_FREE,
		S_RECONF
	} state_t;

	state_t               state;
	vid_pkg::pixclk_sel_t sel_d;
	logic [TMO_W-1:0]     tmo_cnt;

	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state           <= S_IDLE;
			sel_d           <= vid_pkg::SEL_24A;
			profile_sel_o   <= vid_pkg::SEL_24A;
			tmo_cnt         <= '0;
			write_rom_req_o <= 1'b0;
			reconfig_req_o  <= 1'b0;
			engine_reset_o  <= 1'b0;
		end else begin
			// pulse outputs
			write_rom_req_o <= 1'b0;
			reconfig_req_o  <= 1'b0;
			engine_reset_o  <= 1'b0;
			case (state)
				S_IDLE: begin
					sel_d <= pixclk_sel_i;
					if (pixclk_sel_i != sel_d) begin
						write_rom_req_o <= 1'b1;
						profile_sel_o   <= pixclk_sel_i;
						state           <= S_SETTLE;
					end
				end
				// give the engine a cycle to raise busy
				S_SETTLE: state <= S_WAIT_FREE;
				S_WAIT_FREE: begin
					if (!engine_busy_i) begin
						reconfig_req_o <= 1'b1;
						tmo_cnt        <= TMO_W'(RECONFIG_TIMEOUT);
						state          <= S_RECONF;
					end
				end
				S_RECONF: begin
					tmo_cnt <= tmo_cnt - 1'b1;
					if (!reconfig_req_o && !engine_busy_i) begin
						state <= S_IDLE;
					end else if (tmo_cnt == TMO_W'(1)) begin
						// PLL never answered, kick the engine
						engine_reset_o <= 1'b1;
						state          <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: hw/pll_scan_engine.sv
`timescale 1ns/1ns

module pll_scan_engine (
	input  logic                 CLOCK_27,
	input  logic                 rst_n_i,
	input  vid_pkg::pixclk_sel_t profile_sel_i,
	input  logic                 write_rom_req_i,
	input  logic                 reconfig_req_i,
	input  logic                 engine_reset_i,
	output logic                 busy_o,
	output logic                 pll_scanclk_o,
	output logic                 pll_scandata_o,
	output logic                 pll_configupdate_o,
	output logic                 pll_areset_o,
	input  logic                 pll_scandone_i
);

	localparam int PB    = vid_pkg::PROFILE_BITS;
	localparam int CNT_W = $clog2(2 * PB);

	logic [PB-1:0]    shift_q;
	logic [CNT_W-1:0] phase_cnt;
	logic             shifting;
	logic             waiting;

	// MSB leads on the scan chain
	assign pll_scandata_o = shift_q[PB-1];
	assign busy_o         = shifting || waiting;

	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			shift_q            <= '0;
			phase_cnt          <= '0;
			shifting           <= 1'b0;
			waiting            <= 1'b0;
			pll_scanclk_o      <= 1'b0;
			pll_configupdate_o <= 1'b0;
			pll_areset_o       <= 1'b0;
		end else begin
			pll_configupdate_o <= 1'b0;
			pll_areset_o       <= 1'b0;
			if (engine_reset_i) begin
				// abort, and restart the PLL if it was reconfiguring
				shifting      <= 1'b0;
				waiting       <= 1'b0;
				pll_scanclk_o <= 1'b0;
				if (waiting)
					pll_areset_o <= 1'b1;
			end else if (write_rom_req_i) begin
				shift_q       <= vid_pkg::profile_of(profile_sel_i);
				phase_cnt     <= '0;
				shifting      <= 1'b1;
				pll_scanclk_o <= 1'b0;
			end else if (shifting) begin
				pll_scanclk_o <= !pll_scanclk_o;
				phase_cnt     <= phase_cnt + 1'b1;
				// next bit goes out as scanclk falls
				if (pll_scanclk_o)
					shift_q <= {shift_q[PB-2:0], 1'b0};
				if (phase_cnt == CNT_W'(2 * PB - 1)) begin
					shifting      <= 1'b0;
					pll_scanclk_o <= 1'b0;
				end
			end else if (reconfig_req_i) begin
				pll_configupdate_o <= 1'b1;
				waiting            <= 1'b1;
			end else if (waiting && pll_scandone_i) begin
				waiting      <= 1'b0;
				pll_areset_o <= 1'b1;
			end
		end
	end

endmodule

// File: hw/video_out.sv
`timescale 1ns/1ns

module video_out (
	input  logic                        CLOCK_27,
	input  logic                        rst_n_i,
	input  logic [vid_pkg::COLOR_W-1:0] red_i,
	input  logic [vid_pkg::COLOR_W-1:0] green_i,
	input  logic [vid_pkg::COLOR_W-1:0] blue_i,
	input  logic                        hsync_i,
	input  logic                        vsync_i,
	input  logic                        ypbpr_i,
	input  vid_pkg::pixclk_sel_t        pixclk_sel_i,
	output logic [vid_pkg::COLOR_W-1:0] vga_r_o,
	output logic [vid_pkg::COLOR_W-1:0] vga_g_o,
	output logic [vid_pkg::COLOR_W-1:0] vga_b_o,
	output logic                        vga_hs_o,
	output logic                        vga_vs_o
);

	// colour difference offset, mid scale
	localparam int MID = 1 << (vid_pkg::COLOR_W - 1);

	int r, g, b;
	logic [vid_pkg::COLOR_W-1:0] y_c, pb_c, pr_c;
	logic composite;
	logic csync;

	function automatic logic [vid_pkg::COLOR_W-1:0] clamp_c(input int v);
		int hi;
		hi = (1 << vid_pkg::COLOR_W) - 1;
		if (v < 0)
			return '0;
		if (v > hi)
			return '1;
		return v[vid_pkg::COLOR_W-1:0];
	endfunction

	// >>> on int floors toward minus infinity
	always_comb begin
		r    = int'(red_i);
		g    = int'(green_i);
		b    = int'(blue_i);
		y_c  = clamp_c((77 * r + 150 * g + 29 * b) >>> 8);
		pb_c = clamp_c(MID + ((128 * b - 43 * r - 85 * g) >>> 8));
		pr_c = clamp_c(MID + ((128 * r - 107 * g - 21 * b) >>> 8));
	end

	// 24 MHz modes and YPbPr get composite sync
	assign composite = ypbpr_i || (pixclk_sel_i[0] == pixclk_sel_i[1]);
	assign csync     = ~(hsync_i ^ vsync_i);

	always_ff @(posedge CLOCK_27) begin
		vga_r_o <= ypbpr_i ? pr_c : red_i;
		vga_g_o <= ypbpr_i ? y_c  : green_i;
		vga_b_o <= ypbpr_i ? pb_c : blue_i;
	end

	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vga_hs_o <= 1'b0;
			vga_vs_o <= 1'b0;
		end else begin
			vga_hs_o <= composite ? csync : hsync_i;
			vga_vs_o <= composite ? 1'b1 : vsync_i;
		end
	end

endmodule

// File: hw/support_top.sv
`timescale 1ns/1ns

module support_top #(
	parameter int RECONFIG_TIMEOUT = 1000,
	parameter int MEM_WORDS        = 1024
) (
	input  logic                        CLOCK_27,
	input  logic                        rst_n_i,
	// loader link
	input  logic                        loader_active_i,
	input  logic                        loader_req_i,
	input  logic [mem_pkg::ADDR_W-1:0]  loader_addr_i,
	input  logic [mem_pkg::DATA_W-1:0]  loader_data_i,
	input  logic [mem_pkg::SEL_W-1:0]   loader_sel_i,
	output logic                        loader_ack_o,
	// core bus
	input  logic                        core_stb_i,
	input  logic                        core_we_i,
	input  logic [mem_pkg::SEL_W-1:0]   core_sel_i,
	input  logic [mem_pkg::ADDR_W-1:0]  core_adr_i,
	input  logic [mem_pkg::DATA_W-1:0]  core_dat_i,
	output logic [mem_pkg::DATA_W-1:0]  core_dat_o,
	output logic                        core_ack_o,
	output logic                        core_reset_o,
	// pixel clock PLL
	input  vid_pkg::pixclk_sel_t        pixclk_sel_i,
	output logic                        pll_scanclk_o,
	output logic                        pll_scandata_o,
	output logic                        pll_configupdate_o,
	output logic                        pll_areset_o,
	input  logic                        pll_scandone_i,
	// video
	input  logic [vid_pkg::COLOR_W-1:0] red_i,
	input  logic [vid_pkg::COLOR_W-1:0] green_i,
	input  logic [vid_pkg::COLOR_W-1:0] blue_i,
	input  logic                        hsync_i,
	input  logic                        vsync_i,
	input  logic                        ypbpr_i,
	output logic [vid_pkg::COLOR_W-1:0] vga_r_o,
	output logic [vid_pkg::COLOR_W-1:0] vga_g_o,
	output logic [vid_pkg::COLOR_W-1:0] vga_b_o,
	output logic                        vga_hs_o,
	output logic                        vga_vs_o
);

	// memory bus
	logic                       ram_stb;
	logic                       ram_we;
	logic [mem_pkg::SEL_W-1:0]  ram_sel;
	logic [mem_pkg::ADDR_W-1:0] ram_adr;
	logic [mem_pkg::DATA_W-1:0] ram_wdat;
	logic [mem_pkg::DATA_W-1:0] ram_rdat;
	logic                       ram_ack;

	// sequencer to scan engine
	logic                 write_rom_req;
	logic                 reconfig_req;
	logic                 engine_reset;
	logic                 engine_busy;
	vid_pkg::pixclk_sel_t profile_sel;

	boot_loader_mux u_mux (
		.CLOCK_27        (CLOCK_27),
		.rst_n_i         (rst_n_i),
		.loader_active_i (loader_active_i),
		.loader_req_i    (loader_req_i),
		.loader_addr_i   (loader_addr_i),
		.loader_data_i   (loader_data_i),
		.loader_sel_i    (loader_sel_i),
		.loader_ack_o    (loader_ack_o),
		.core_stb_i      (core_stb_i),
		.core_we_i       (core_we_i),
		.core_sel_i      (core_sel_i),
		.core_adr_i      (core_adr_i),
		.core_dat_i      (core_dat_i),
		.core_dat_o      (core_dat_o),
		.core_ack_o      (core_ack_o),
		.core_reset_o    (core_reset_o),
		.ram_stb_o       (ram_stb),
		.ram_we_o        (ram_we),
		.ram_sel_o       (ram_sel),
		.ram_adr_o       (ram_adr),
		.ram_wdat_o      (ram_wdat),
		.ram_rdat_i      (ram_rdat),
		.ram_ack_i       (ram_ack)
	);

	word_ram #(
		.MEM_WORDS (MEM_WORDS)
	) u_ram (
		.CLOCK_27   (CLOCK_27),
		.rst_n_i    (rst_n_i),
		.ram_stb_i  (ram_stb),
		.ram_we_i   (ram_we),
		.ram_sel_i  (ram_sel),
		.ram_adr_i  (ram_adr),
		.ram_wdat_i (ram_wdat),
		.ram_rdat_o (ram_rdat),
		.ram_ack_o  (ram_ack)
	);

	pixclk_reconfig #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) u_reconfig (
		.CLOCK_27        (CLOCK_27),
		.rst_n_i         (rst_n_i),
		.pixclk_sel_i    (pixclk_sel_i),
		.engine_busy_i   (engine_busy),
		.write_rom_req_o (write_rom_req),
		.reconfig_req_o  (reconfig_req),
		.engine_reset_o  (engine_reset),
		.profile_sel_o   (profile_sel)
	);

	pll_scan_engine u_scan (
		.CLOCK_27           (CLOCK_27),
		.rst_n_i            (rst_n_i),
		.profile_sel_i      (profile_sel),
		.write_rom_req_i    (write_rom_req),
		.reconfig_req_i     (reconfig_req),
		.engine_reset_i     (engine_reset),
		.busy_o             (engine_busy),
		.pll_scanclk_o      (pll_scanclk_o),
		.pll_scandata_o     (pll_scandata_o),
		.pll_configupdate_o (pll_configupdate_o),
		.pll_areset_o       (pll_areset_o),
		.pll_scandone_i     (pll_scandone_i)
	);

	video_out u_video (
		.CLOCK_27     (CLOCK_27),
		.rst_n_i      (rst_n_i),
		.red_i        (red_i),
		.green_i      (green_i),
		.blue_i       (blue_i),
		.hsync_i      (hsync_i),
		.vsync_i      (vsync_i),
		.ypbpr_i      (ypbpr_i),
		.pixclk_sel_i (pixclk_sel_i),
		.vga_r_o      (vga_r_o),
		.vga_g_o      (vga_g_o),
		.vga_b_o      (vga_b_o),
		.vga_hs_o     (vga_hs_o),
		.vga_vs_o     (vga_vs_o)
	);

endmodule

// File: verif/support_top_chk.sv
`timescale 1ns/1ns

module support_top_chk (
	input logic CLOCK_27,
	input logic rst_n_i,
	input logic loader_active_i,
	input logic loader_req_i,
	input logic loader_ack_o,
	input logic core_ack_o,
	input logic pll_configupdate_o,
	input logic pll_areset_o
);

	// a configupdate is waiting for its areset
	logic update_pending;

	always_ff @(posedge CLOCK_27 or negedge rst_n_i) begin
		if (!rst_n_i)
			update_pending <= 1'b0;
		else if (pll_configupdate_o)
			update_pending <= 1'b1;
		else if (pll_areset_o)
			update_pending <= 1'b0;
	end

	ack_held_with_req: assert property (@(posedge CLOCK_27) disable iff (!rst_n_i)
		loader_ack_o && loader_req_i |=> loader_ack_o)
		else $error("loader ack dropped while req was still high");

	core_blocked_while_loading: assert property (@(posedge CLOCK_27) disable iff (!rst_n_i)
		!(core_ack_o && loader_active_i))
		else $error("core ack seen during a download");

	configupdate_one_cycle: assert property (@(posedge CLOCK_27) disable iff (!rst_n_i)
		pll_configupdate_o |=> !pll_configupdate_o)
		else $error("configupdate held longer than one cycle");

	areset_after_update: assert property (@(posedge CLOCK_27) disable iff (!rst_n_i)
		pll_areset_o |-> update_pending)
		else $error("PLL areset without a configupdate before it");

endmodule

bind support_top support_top_chk u_chk (
	.CLOCK_27           (CLOCK_27),
	.rst_n_i            (rst_n_i),
	.loader_active_i    (loader_active_i),
	.loader_req_i       (loader_req_i),
	.loader_ack_o       (loader_ack_o),
	.core_ack_o         (core_ack_o),
	.pll_configupdate_o (pll_configupdate_o),
	.pll_areset_o       (pll_areset_o)
);

// File: verif/tb_support_top.sv
`timescale 1ns/1ns

module tb_support_top;

	localparam int TMO = 64;
	localparam int TMO_WAIT = 200;

	logic                        CLOCK_27;
	logic                        rst_n_i;
	logic                        loader_active_i;
	logic                        loader_req_i;
	logic [mem_pkg::ADDR_W-1:0]  loader_addr_i;
	logic [mem_pkg::DATA_W-1:0]  loader_data_i;
	logic [mem_pkg::SEL_W-1:0]   loader_sel_i;
	logic                        loader_ack_o;
	logic                        core_stb_i;
	logic                        core_we_i;
	logic [mem_pkg::SEL_W-1:0]   core_sel_i;
	logic [mem_pkg::ADDR_W-1:0]  core_adr_i;
	logic [mem_pkg::DATA_W-1:0]  core_dat_i;
	logic [mem_pkg::DATA_W-1:0]  core_dat_o;
	logic                        core_ack_o;
	logic                        core_reset_o;
	vid_pkg::pixclk_sel_t        pixclk_sel_i;
	logic                        pll_scanclk_o;
	logic                        pll_scandata_o;
	logic                        pll_configupdate_o;
	logic                        pll_areset_o;
	logic                        pll_scandone_i;
	logic [vid_pkg::COLOR_W-1:0] red_i;
	logic [vid_pkg::COLOR_W-1:0] green_i;
	logic [vid_pkg::COLOR_W-1:0] blue_i;
	logic [vid_pkg::COLOR_W-1:0] vga_r_o;
	logic [vid_pkg::COLOR_W-1:0] vga_g_o;
	logic [vid_pkg::COLOR_W-1:0] vga_b_o;
	logic                        hsync_i;
	logic                        vsync_i;
	logic                        ypbpr_i;
	logic                        vga_hs_o;
	logic                        vga_vs_o;

	logic [31:0] rng = 32'hc454_8055;
	int errors = 0;
	int tests = 0;
	int failing = 0;
	logic [31:0] image [0:15];

	support_top #(.RECONFIG_TIMEOUT(TMO)) dut_i (.*);

	initial begin
		CLOCK_27 = 1'b0;
		forever #10 CLOCK_27 = ~CLOCK_27;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int floor_div256(input int n);
		int q;
		q = n / 256;
		if ((n % 256) != 0 && n < 0)
			q = q - 1;
		return q;
	endfunction

	function automatic int clamp63(input int v);
		return (v < 0) ? 0 : ((v > 63) ? 63 : v);
	endfunction

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors != err_before)
			failing++;
		$display("test %0s: %0d errors", name, errors - err_before);
	endtask

	task automatic loader_write(input logic [9:0] adr, input logic [31:0] dat);
		int n;
		@(posedge CLOCK_27);
		loader_addr_i <= adr;
		loader_data_i <= dat;
		loader_sel_i  <= 4'hf;
		loader_req_i  <= 1'b1;
		n = 0;
		do begin
			@(posedge CLOCK_27);
			n++;
		end while (!loader_ack_o && n < TMO);
		if (!loader_ack_o) begin
			$display("timeout: loader ack never rose at %0t", $time);
			errors++;
		end
		loader_req_i <= 1'b0;
		n = 0;
		do begin
			@(posedge CLOCK_27);
			n++;
		end while (loader_ack_o && n < TMO);
		if (loader_ack_o) begin
			$display("timeout: loader ack never fell at %0t", $time);
			errors++;
		end
	endtask

	task automatic core_access(input logic we, input logic [3:0] sel, input logic [9:0] adr,
			input logic [31:0] dat, output logic [31:0] rd);
		int n;
		@(posedge CLOCK_27);
		core_stb_i <= 1'b1;
		core_we_i  <= we;
		core_sel_i <= sel;
		core_adr_i <= adr;
		core_dat_i <= dat;
		n = 0;
		do begin
			@(posedge CLOCK_27);
			n++;
		end while (!core_ack_o && n < TMO_WAIT);
		if (!core_ack_o) begin
			$display("timeout: core ack never arrived at %0t", $time);
			errors++;
		end
		rd = core_dat_o;
		core_stb_i <= 1'b0;
	endtask

	task automatic wait_pulse(input bit on_areset, input int limit);
		int n;
		n = 0;
		do begin
			@(posedge CLOCK_27);
			n++;
		end while (!(on_areset ? pll_areset_o : pll_configupdate_o) && n < limit);
		if (!(on_areset ? pll_areset_o : pll_configupdate_o)) begin
			$display("timeout: no PLL %0s pulse at %0t",
				on_areset ? "areset" : "configupdate", $time);
			errors++;
		end
	endtask

	// sample data on each rising scanclk with the MSB first
	task automatic capture_profile(input logic [15:0] expected);
		logic [15:0] got;
		logic prev;
		int bits;
		int n;
		bits = 0;
		n = 0;
		prev = 1'b0;
		while (bits < 16 && n < 4 * vid_pkg::PROFILE_BITS + 16) begin
			@(posedge CLOCK_27);
			n++;
			if (pll_scanclk_o && !prev) begin
				got = {got[14:0], pll_scandata_o};
				bits++;
			end
			prev = pll_scanclk_o;
		end
		if (bits < 16) begin
			$display("timeout: only %0d scan bits seen at %0t", bits, $time);
			errors++;
		end else
			assert (got == expected) else begin
				$display("MISMATCH %0t: profile %h, expected %h", $time, got, expected);
				errors++;
			end
	endtask

	task automatic answer_pll();
		int extra;
		wait_pulse(1'b0, TMO);
		@(posedge CLOCK_27);
		pll_scandone_i <= 1'b1;
		wait_pulse(1'b1, TMO);
		pll_scandone_i <= 1'b0;
		extra = 0;
		repeat (8) begin
			@(posedge CLOCK_27);
			if (pll_areset_o)
				extra++;
		end
		assert (extra == 0) else begin
			$display("MISMATCH %0t: %0d extra areset pulses", $time, extra);
			errors++;
		end
	endtask

	initial begin
		int e0;
		int n;
		int r;
		int g;
		int b;
		int ey;
		int epb;
		int epr;
		logic [31:0] rd;
		logic [31:0] w;
		logic [31:0] v;
		logic [31:0] exp_w;
		logic [3:0] sel;
		logic comp;
		rst_n_i = 1'b0;
		loader_active_i = 1'b0;
		loader_req_i = 1'b0;
		loader_addr_i = '0;
		loader_data_i = '0;
		loader_sel_i = '0;
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
		core_sel_i = '0;
		core_adr_i = '0;
		core_dat_i = '0;
		pixclk_sel_i = vid_pkg::SEL_24A;
		pll_scandone_i = 1'b0;
		red_i = '0;
		green_i = '0;
		blue_i = '0;
		hsync_i = 1'b0;
		vsync_i = 1'b0;
		ypbpr_i = 1'b0;
		repeat (2) @(posedge CLOCK_27);
		rst_n_i <= 1'b1;

		e0 = errors;
		@(posedge CLOCK_27);
		loader_active_i <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			image[i] = next_rand();
			loader_write(10'(i), image[i]);
		end
		assert (core_reset_o) else begin
			$display("MISMATCH %0t: core reset released during load", $time);
			errors++;
		end
		loader_active_i <= 1'b0;
		n = 0;
		do begin
			@(posedge CLOCK_27);
			n++;
		end while (core_reset_o && n < TMO);
		if (core_reset_o) begin
			$display("timeout: core reset still high after the load at %0t", $time);
			errors++;
		end
		for (int i = 0; i < 16; i++) begin
			core_access(1'b0, 4'h0, 10'(i), '0, rd);
			assert (rd == image[i]) else begin
				$display("MISMATCH %0t: word %0d read %h, expected %h", $time, i, rd, image[i]);
				errors++;
			end
		end
		report_test("load_readback", e0);

		e0 = errors;
		w = next_rand();
		@(posedge CLOCK_27);
		loader_active_i <= 1'b1;
		core_stb_i <= 1'b1;
		core_we_i  <= 1'b0;
		core_adr_i <= 10'd16;
		loader_write(10'd16, w);
		repeat (4) begin
			@(posedge CLOCK_27);
			assert (!core_ack_o) else begin
				$display("MISMATCH %0t: core ack while loading", $time);
				errors++;
			end
		end
		loader_active_i <= 1'b0;
		n = 0;
		do begin
			@(posedge CLOCK_27);
			n++;
		end while (!core_ack_o && n < TMO);
		if (!core_ack_o) begin
			$display("timeout: blocked core read never completed at %0t", $time);
			errors++;
		end
		assert (core_dat_o == w) else begin
			$display("MISMATCH %0t: blocked read %h, expected %h", $time, core_dat_o, w);
			errors++;
		end
		core_stb_i <= 1'b0;
		report_test("core_blocked", e0);

		e0 = errors;
		v = next_rand();
		core_access(1'b1, 4'hf, 10'd20, v, rd);
		exp_w = v;
		for (int k = 0; k < 3; k++) begin
			sel = (k == 0) ? 4'b0101 : ((k == 1) ? 4'b1000 : 4'b0011);
			w = next_rand();
			core_access(1'b1, sel, 10'd20, w, rd);
			for (int j = 0; j < 4; j++)
				if (sel[j])
					exp_w[8*j +: 8] = w[8*j +: 8];
			core_access(1'b0, 4'h0, 10'd20, '0, rd);
			assert (rd == exp_w) else begin
				$display("MISMATCH %0t: sel %b read %h, expected %h", $time, sel, rd, exp_w);
				errors++;
			end
		end
		report_test("byte_lanes", e0);

		e0 = errors;
		@(posedge CLOCK_27);
		pixclk_sel_i <= vid_pkg::SEL_25;
		capture_profile(vid_pkg::PROFILE_ROM[1]);
		answer_pll();
		report_test("profile_shift", e0);

		e0 = errors;
		@(posedge CLOCK_27);
		pixclk_sel_i <= vid_pkg::SEL_36;
		wait_pulse(1'b1, TMO + 2 * vid_pkg::PROFILE_BITS + 16);
		@(posedge CLOCK_27);
		pixclk_sel_i <= vid_pkg::SEL_24B;
		capture_profile(vid_pkg::PROFILE_ROM[0]);
		answer_pll();
		report_test("pll_timeout", e0);

		e0 = errors;
		for (int i = 0; i < 32; i++) begin
			@(posedge CLOCK_27);
			w = next_rand();
			red_i <= w[5:0];
			green_i <= w[11:6];
			blue_i <= w[17:12];
			hsync_i <= w[18];
			vsync_i <= w[19];
			ypbpr_i <= 1'((i / 4) % 2);
			pixclk_sel_i <= vid_pkg::pixclk_sel_t'(i % 4);
			r = int'(w[5:0]);
			g = int'(w[11:6]);
			b = int'(w[17:12]);
			ey = clamp63(floor_div256(77 * r + 150 * g + 29 * b));
			epb = clamp63(32 + floor_div256(128 * b - 43 * r - 85 * g));
			epr = clamp63(32 + floor_div256(128 * r - 107 * g - 21 * b));
			if ((i / 4) % 2 == 0) begin
				ey = g;
				epb = b;
				epr = r;
			end
			comp = ((i / 4) % 2 == 1) || ((i % 4) == 0) || ((i % 4) == 3);
			@(posedge CLOCK_27);
			@(negedge CLOCK_27);
			assert (int'(vga_r_o) == epr && int'(vga_g_o) == ey && int'(vga_b_o) == epb)
			else begin
				$display("MISMATCH %0t: colour %0d %0d %0d, expected %0d %0d %0d", $time,
					vga_r_o, vga_g_o, vga_b_o, epr, ey, epb);
				errors++;
			end
			assert (vga_hs_o == (comp ? (w[18] == w[19]) : w[18])
					&& vga_vs_o == (comp ? 1'b1 : w[19])) else begin
				$display("MISMATCH %0t: sync hs %b vs %b", $time, vga_hs_o, vga_vs_o);
				errors++;
			end
		end
		report_test("video", e0);

		$display("tests %0d, failing %0d, errors %0d", tests, failing, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tb.f
hw/mem_pkg.sv
hw/vid_pkg.sv
hw/boot_loader_mux.sv
hw/word_ram.sv
hw/pixclk_reconfig.sv
hw/pll_scan_engine.sv
hw/video_out.sv
hw/support_top.sv
verif/support_top_chk.sv
verif/tb_support_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_support_top
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
